/* hdl/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath width, also used for the PC
`define CPU_DATA_W 32

// Register file address width, 32 entries
`define CPU_REG_AW 5

// Hardware stack pointer
`define CPU_SP_REG 29
`define CPU_SP_RESET 32'h0000_0C00 // Top of stack after reset

// Slots on the execute side, one credit each
`define CPU_EX_CREDITS 2

`endif

/* hdl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// Field widths
	localparam int OPCODE_W = 6;
	localparam int SHAMT_W  = 5;
	localparam int IMM_I_W  = 16; // I-type immediate
	localparam int IMM_J_W  = 26; // J-type immediate, also the jump target

	// Low bit of each register field
	localparam int RD_LSB    = 21;
	localparam int RS_LSB    = 16;
	localparam int RT_LSB    = 11;
	localparam int SHAMT_LSB = 6;

	// Opcode in instr[31:26], values not listed decode as NOP
	typedef enum logic [OPCODE_W-1:0] {
		OP_ADD    = 6'd0,
		OP_SUB    = 6'd1,
		OP_AND    = 6'd2,
		OP_NAND   = 6'd3,
		OP_XOR    = 6'd4,
		OP_ADDI   = 6'd8,
		OP_ANDI   = 6'd9,
		OP_LW     = 6'd10,
		OP_SW     = 6'd11,
		OP_BRANCH = 6'd12,
		OP_SLL    = 6'd16,
		OP_SRL    = 6'd17,
		OP_PUSH   = 6'd20, // Stack ops
		OP_POP    = 6'd21,
		OP_CALL   = 6'd22,
		OP_RET    = 6'd23,
		OP_JUMP   = 6'd24
	} opcode_e;

	// ALU operand source
	typedef enum logic [1:0] {
		SRC_REGS  = 2'd0, // Both operands from the register file
		SRC_IMM   = 2'd1, // Register or PC, plus immediate
		SRC_SHIFT = 2'd2  // Register plus shamt or stack step
	} alu_src_e;

endpackage

`default_nettype wire

/* hdl/pipe_pkg.sv */
`default_nettype none

`include "cpu_cfg.svh"

package pipe_pkg;

	// Decoded control, one bit per function
	typedef struct packed {
		logic call;
		logic ret;
		logic branch;
		logic push;
		logic pop;
		logic reg_2_sel;              // Second read from rt, else rd
		logic sign_ext_sel;           // J immediate in place of I immediate
		isa_pkg::alu_src_e alu_src;
		logic reg_write;              // Instruction writes rd
	} dec_ctrl_t;

	// Bundle handed to execute
	typedef struct packed {
		isa_pkg::opcode_e opcode;
		logic [`CPU_REG_AW-1:0] dest;     // Writeback register
		logic [`CPU_DATA_W-1:0] alu_a;
		logic [`CPU_DATA_W-1:0] alu_b;
		logic [`CPU_DATA_W-1:0] mem_data; // Store data
		logic [isa_pkg::IMM_J_W-1:0] jump_target;
		logic [`CPU_DATA_W-1:0] pc;
	} issue_t;

	// Roughly 165 bits in the issue bundle, so it stays flat in the ID/EX register
	// and gets split out again at the top level

endpackage

`default_nettype wire

/* hdl/regfile_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

interface regfile_if;

	// Two read ports
	logic [`CPU_REG_AW-1:0] rd_addr_1;
	logic [`CPU_REG_AW-1:0] rd_addr_2;
	logic [`CPU_DATA_W-1:0] rd_data_1;
	logic [`CPU_DATA_W-1:0] rd_data_2;

	// One write port, lands at the clock edge
	logic                   wr_en;
	logic [`CPU_REG_AW-1:0] wr_addr;
	logic [`CPU_DATA_W-1:0] wr_data;

	// Decode side
	modport client (
		output rd_addr_1, rd_addr_2, wr_en, wr_addr, wr_data,
		input  rd_data_1, rd_data_2
	);

	// Storage side
	modport server (
		input  rd_addr_1, rd_addr_2, wr_en, wr_addr, wr_data,
		output rd_data_1, rd_data_2
	);

endinterface

`default_nettype wire

/* hdl/decode_control.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_control (
	input  isa_pkg::opcode_e    opcode,
	output pipe_pkg::dec_ctrl_t ctrl
);

	import isa_pkg::*;

	always_comb begin
		ctrl = '0; // NOP unless matched below
		ctrl.alu_src = SRC_REGS;

		case (opcode)
			// R-type ALU ops, rs op rt
			OP_ADD, OP_SUB, OP_AND, OP_NAND, OP_XOR: begin
				ctrl.reg_2_sel = 1'b1;
				ctrl.reg_write = 1'b1;
			end

			OP_ADDI, OP_ANDI, OP_LW: begin
				ctrl.alu_src   = SRC_IMM;
				ctrl.reg_write = 1'b1;
			end

			OP_SW: ctrl.alu_src = SRC_IMM; // Address calc, rd read as store data

			OP_BRANCH: begin
				ctrl.alu_src = SRC_IMM;
				ctrl.branch  = 1'b1; // PC plus offset
			end

			// Shifts by shamt
			OP_SLL, OP_SRL: begin
				ctrl.alu_src   = SRC_SHIFT;
				ctrl.reg_write = 1'b1;
			end

			// Stack ops step SP by one
			OP_PUSH: begin
				ctrl.alu_src = SRC_SHIFT;
				ctrl.push    = 1'b1;
			end
			OP_POP: begin
				ctrl.alu_src   = SRC_SHIFT;
				ctrl.pop       = 1'b1;
				ctrl.reg_write = 1'b1; // Popped word goes to rd
			end
			OP_CALL: begin
				ctrl.alu_src = SRC_SHIFT;
				ctrl.call    = 1'b1;
			end
			OP_RET: begin
				ctrl.alu_src = SRC_SHIFT;
				ctrl.ret     = 1'b1;
			end

			OP_JUMP: begin
				ctrl.alu_src      = SRC_IMM;
				ctrl.sign_ext_sel = 1'b1; // 26-bit field
			end

			default: ; // Unassigned opcodes
		endcase
	end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module reg_file (
	input logic clk,
	regfile_if.server rf
);

	localparam int DEPTH = 1 << `CPU_REG_AW;

	// SP gets its reset value through the write port
	logic [`CPU_DATA_W-1:0] regs [DEPTH];

	logic hit_1; // Write to the address on port 1
	logic hit_2;

	always_ff @(posedge clk) begin
		if (rf.wr_en) begin
			regs[rf.wr_addr] <= rf.wr_data;
		end
	end

	assign hit_1 = rf.wr_en && (rf.wr_addr == rf.rd_addr_1);
	assign hit_2 = rf.wr_en && (rf.wr_addr == rf.rd_addr_2);

	// Bypass so a same-cycle write is seen by decode
	assign rf.rd_data_1 = hit_1 ? rf.wr_data : regs[rf.rd_addr_1];
	assign rf.rd_data_2 = hit_2 ? rf.wr_data : regs[rf.rd_addr_2];

endmodule

`default_nettype wire

/* hdl/id_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module id_unit (
	input  logic                   rst,
	input  logic [`CPU_DATA_W-1:0] instr,
	input  logic [`CPU_DATA_W-1:0] pc,
	input  pipe_pkg::dec_ctrl_t    ctrl,

	// Writeback and stack pop from later stages
	input  logic                   wb_en,
	input  logic [`CPU_REG_AW-1:0] wb_reg,
	input  logic [`CPU_DATA_W-1:0] wb_data,
	input  logic                   pop_en,
	input  logic [`CPU_DATA_W-1:0] pop_data,

	regfile_if.client rf,
	output pipe_pkg::issue_t       issue
);

	import isa_pkg::*;

	localparam logic [`CPU_REG_AW-1:0] SP = `CPU_REG_AW'(`CPU_SP_REG);

	// Instruction fields
	logic [`CPU_REG_AW-1:0] f_rd;
	logic [`CPU_REG_AW-1:0] f_rs;
	logic [`CPU_REG_AW-1:0] f_rt;
	logic [SHAMT_W-1:0]     f_shamt;
	logic [IMM_I_W-1:0]     imm_i;
	logic [IMM_J_W-1:0]     imm_j;

	logic                   sp_update; // Stack op, SP on port 1
	logic [`CPU_DATA_W-1:0] imm_ext;
	logic [`CPU_DATA_W-1:0] shamt_ext;

	assign f_rd    = instr[RD_LSB +: `CPU_REG_AW];
	assign f_rs    = instr[RS_LSB +: `CPU_REG_AW];
	assign f_rt    = instr[RT_LSB +: `CPU_REG_AW];
	assign f_shamt = instr[SHAMT_LSB +: SHAMT_W];
	assign imm_i   = instr[IMM_I_W-1:0];
	assign imm_j   = instr[IMM_J_W-1:0];

	assign sp_update = ctrl.call | ctrl.ret | ctrl.push | ctrl.pop;

	// Read port selection
	assign rf.rd_addr_1 = sp_update ? SP : f_rs;
	assign rf.rd_addr_2 = ctrl.reg_2_sel ? f_rt : f_rd; // rd for stores

	// Sign extension, J field for jumps
	assign imm_ext = ctrl.sign_ext_sel ?
		{{(`CPU_DATA_W-IMM_J_W){imm_j[IMM_J_W-1]}}, imm_j} :
		{{(`CPU_DATA_W-IMM_I_W){imm_i[IMM_I_W-1]}}, imm_i};

	assign shamt_ext = {{(`CPU_DATA_W-SHAMT_W){1'b0}}, f_shamt};

	// ALU operand mux
	always_comb begin
		case (ctrl.alu_src)
			SRC_REGS: begin
				issue.alu_a = rf.rd_data_1;
				issue.alu_b = rf.rd_data_2;
			end
			SRC_IMM: begin
				issue.alu_a = ctrl.branch ? pc : rf.rd_data_1; // Branch target from PC
				issue.alu_b = imm_ext;
			end
			SRC_SHIFT: begin
				issue.alu_a = rf.rd_data_1;
				issue.alu_b = sp_update ? `CPU_DATA_W'(1) : shamt_ext; // SP step of one
			end
			default: begin
				issue.alu_a = '0; // Unused source code
				issue.alu_b = '0;
			end
		endcase
	end

	// Destination, SP for ops that move it here
	assign issue.dest = (ctrl.call | ctrl.ret | ctrl.push) ? SP : f_rd;

	assign issue.opcode      = opcode_e'(instr[`CPU_DATA_W-1 -: OPCODE_W]);
	assign issue.mem_data    = rf.rd_data_2;
	assign issue.jump_target = imm_j;
	assign issue.pc          = pc;

	// Write port arbitration
	always_comb begin
		if (rst) begin
			// SP reload on every reset edge
			rf.wr_en   = 1'b1;
			rf.wr_addr = SP;
			rf.wr_data = `CPU_SP_RESET;
		end else if (pop_en) begin
			rf.wr_en   = 1'b1; // Pop beats normal writeback
			rf.wr_addr = SP;
			rf.wr_data = pop_data;
		end else begin
			rf.wr_en   = wb_en;
			rf.wr_addr = wb_reg;
			rf.wr_data = wb_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/issue_credit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module issue_credit (
	input  logic             clk,
	input  logic             rst,

	// Upstream side
	input  logic             instr_valid,
	input  logic             data_hazard,
	output logic             instr_ready,
	input  pipe_pkg::issue_t issue_in,

	// Execute side, credit based
	input  logic             ex_credit,
	output logic             ex_valid,
	output pipe_pkg::issue_t issue_out
);

	localparam int CNT_W = $clog2(`CPU_EX_CREDITS + 1);

	logic [CNT_W-1:0] credits; // Free slots downstream
	logic             accept;

	// Stall on hazard or when downstream is full
	assign instr_ready = (credits != '0) && !data_hazard;
	assign accept      = instr_valid && instr_ready;

	// Credit counter
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CNT_W'(`CPU_EX_CREDITS);
		end else begin
			case ({accept, ex_credit})
				2'b10:   credits <= credits - CNT_W'(1); // Spend
				2'b01:   credits <= credits + CNT_W'(1); // Return
				default: ; // Both or neither
			endcase
		end
	end

	// One-cycle valid per accept
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= accept;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		if (accept) begin
			issue_out <= issue_in;
		end
	end

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module decode_stage (
	input  logic                          clk,
	input  logic                          rst,

	// From fetch
	input  logic                          instr_valid,
	output logic                          instr_ready,
	input  logic [`CPU_DATA_W-1:0]        instr,
	input  logic [`CPU_DATA_W-1:0]        pc,
	input  logic                          data_hazard,

	// Writeback and stack pop
	input  logic                          wb_en,
	input  logic [`CPU_REG_AW-1:0]        wb_reg,
	input  logic [`CPU_DATA_W-1:0]        wb_data,
	input  logic                          pop_en,
	input  logic [`CPU_DATA_W-1:0]        pop_data,

	// To execute
	input  logic                          ex_credit,
	output logic                          ex_valid,
	output logic [isa_pkg::OPCODE_W-1:0]  ex_opcode,
	output logic [`CPU_REG_AW-1:0]        ex_dest,
	output logic [`CPU_DATA_W-1:0]        ex_alu_a,
	output logic [`CPU_DATA_W-1:0]        ex_alu_b,
	output logic [`CPU_DATA_W-1:0]        ex_mem_data,
	output logic [isa_pkg::IMM_J_W-1:0]   ex_jump_target,
	output logic [`CPU_DATA_W-1:0]        ex_pc
);

	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_e   id_opcode;
	dec_ctrl_t id_ctrl;
	issue_t    id_issue; // Decoded, combinational
	issue_t    ex_issue; // Registered

	regfile_if rf_bus ();

	assign id_opcode = opcode_e'(instr[`CPU_DATA_W-1 -: OPCODE_W]);

	decode_control u_decode_control (.opcode(id_opcode), .ctrl(id_ctrl));

	reg_file u_reg_file (.clk(clk), .rf(rf_bus.server));

	id_unit u_id_unit (
		.rst(rst), .instr(instr), .pc(pc), .ctrl(id_ctrl),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
		.pop_en(pop_en), .pop_data(pop_data),
		.rf(rf_bus.client), .issue(id_issue)
	);

	issue_credit u_issue_credit (
		.clk(clk), .rst(rst),
		.instr_valid(instr_valid), .data_hazard(data_hazard), .instr_ready(instr_ready),
		.issue_in(id_issue), .ex_credit(ex_credit),
		.ex_valid(ex_valid), .issue_out(ex_issue)
	);

	// Flatten the bundle onto the ex_ ports
	assign ex_opcode      = ex_issue.opcode;
	assign ex_dest        = ex_issue.dest;
	assign ex_alu_a       = ex_issue.alu_a;
	assign ex_alu_b       = ex_issue.alu_b;
	assign ex_mem_data    = ex_issue.mem_data;
	assign ex_jump_target = ex_issue.jump_target;
	assign ex_pc          = ex_issue.pc;

endmodule

`default_nettype wire

/* testbench/tb_decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_decode_stage;

	localparam int N_ROWS      = 13;
	localparam int CREDITS     = `CPU_EX_CREDITS;
	localparam int RAND_CYCLES = 60;
	localparam int CREDIT_LEN  = RAND_CYCLES + 2 * CREDITS + 10; // Hazard, fill, random, drain
	localparam int LIMIT       = N_ROWS * 4 + CREDIT_LEN + 50;

	// Opcode encodings
	localparam logic [5:0] OPC_ADD = 6'd0, OPC_XOR = 6'd4, OPC_ADDI = 6'd8, OPC_BRANCH = 6'd12;
	localparam logic [5:0] OPC_SLL = 6'd16, OPC_SRL = 6'd17, OPC_PUSH = 6'd20, OPC_POP = 6'd21;
	localparam logic [5:0] OPC_CALL = 6'd22, OPC_RET = 6'd23, OPC_JUMP = 6'd24;

	typedef struct packed {
		logic        pre_en;   // Writeback preset in the decode cycle
		logic [4:0]  pre_reg;
		logic [31:0] pre_data;
		logic        pop;      // Stack pop in the same cycle
		logic [31:0] pop_val;
		logic [31:0] ins;
		logic [31:0] pcv;
		logic [5:0]  e_op;     // Expected issue fields
		logic [4:0]  e_dest;
		logic [31:0] e_a;
		logic [31:0] e_b;
		logic [31:0] e_md;
	} row_t;

	logic clk, rst, instr_valid, instr_ready, data_hazard;
	logic [31:0] instr, pc, wb_data, pop_data;
	logic [4:0] wb_reg;
	logic wb_en, pop_en, ex_credit, ex_valid;
	logic [5:0] ex_opcode;
	logic [4:0] ex_dest;
	logic [31:0] ex_alu_a, ex_alu_b, ex_mem_data, ex_pc;
	logic [25:0] ex_jump_target;

	row_t rows [N_ROWS];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int issued, returned, model_credits; // Credit phase bookkeeping

	decode_stage u_dut (.*);

	always #5 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", LIMIT);
			$display("errors: %0d of %0d checks", errors, checks);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic logic [31:0] enc_r(input logic [5:0] op, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		return {op, rd, rs, rt, shamt, 6'd0};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rd,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rd, rs, imm};
	endfunction

	task automatic set_row(input int idx, input logic pe, input logic [4:0] pr,
		input logic [31:0] pd, input logic pp, input logic [31:0] pv, input logic [31:0] ins,
		input logic [31:0] pcv, input logic [5:0] op, input logic [4:0] dest,
		input logic [31:0] a, input logic [31:0] b, input logic [31:0] md);
		rows[idx] = '{pe, pr, pd, pp, pv, ins, pcv, op, dest, a, b, md};
	endtask

	// Registers other than SP hold only what the presets write
	task automatic build_table();
		set_row(0, 1, 5, 32'h5555_0005, 0, 0, enc_r(OPC_PUSH, 5, 0, 0, 0), 32'h100,
			OPC_PUSH, 29, 32'h0000_0C00, 1, 32'h5555_0005); // rd bypass on port 2
		set_row(1, 1, 6, 32'h0000_0066, 0, 0, enc_r(OPC_CALL, 5, 0, 0, 0), 32'h104,
			OPC_CALL, 29, 32'h0000_0C00, 1, 32'h5555_0005);
		set_row(2, 1, 7, 32'h7777_0007, 0, 0, enc_r(OPC_RET, 6, 0, 0, 0), 32'h108,
			OPC_RET, 29, 32'h0000_0C00, 1, 32'h0000_0066);
		set_row(3, 1, 8, 32'h1234_5678, 0, 0, enc_r(OPC_ADD, 3, 5, 8, 0), 32'h10C,
			OPC_ADD, 3, 32'h5555_0005, 32'h1234_5678, 32'h1234_5678); // rt written this cycle
		set_row(4, 1, 9, 32'hDEAD_BEEF, 0, 0, enc_r(OPC_XOR, 2, 9, 7, 0), 32'h110,
			OPC_XOR, 2, 32'hDEAD_BEEF, 32'h7777_0007, 32'h7777_0007); // rs written this cycle
		set_row(5, 1, 10, 32'h0000_00AA, 0, 0, enc_i(OPC_ADDI, 10, 7, 16'hFFF0), 32'h114,
			OPC_ADDI, 10, 32'h7777_0007, 32'hFFFF_FFF0, 32'h0000_00AA); // Imm of -16
		set_row(6, 0, 0, 0, 0, 0, enc_i(OPC_BRANCH, 6, 5, 16'h0040), 32'h1000,
			OPC_BRANCH, 6, 32'h0000_1000, 32'h0000_0040, 32'h0000_0066);
		set_row(7, 0, 0, 0, 0, 0, {OPC_JUMP, 26'h3A5_0123}, 32'h118,
			OPC_JUMP, 29, 32'h5555_0005, 32'hFFA5_0123, 32'h0000_0C00); // Field holds rd 29 and rs 5
		set_row(8, 1, 11, 32'h0000_0B0B, 0, 0, enc_r(OPC_SLL, 11, 7, 0, 13), 32'h11C,
			OPC_SLL, 11, 32'h7777_0007, 32'd13, 32'h0000_0B0B);
		set_row(9, 1, 12, 32'hC0C0_0012, 0, 0, enc_r(OPC_POP, 12, 3, 0, 7), 32'h120,
			OPC_POP, 12, 32'h0000_0C00, 1, 32'hC0C0_0012); // SP read in place of rs
		set_row(10, 1, 29, 32'h1111_1111, 1, 32'h0000_0BF8, enc_r(OPC_SRL, 5, 9, 0, 31), 32'h124,
			OPC_SRL, 5, 32'hDEAD_BEEF, 32'd31, 32'h5555_0005); // Pop against wb to SP
		set_row(11, 0, 0, 0, 0, 0, enc_r(OPC_PUSH, 7, 0, 0, 0), 32'h128,
			OPC_PUSH, 29, 32'h0000_0BF8, 1, 32'h7777_0007); // Popped SP visible
		set_row(12, 0, 0, 0, 0, 0, enc_r(6'd63, 7, 5, 0, 0), 32'h12C,
			6'd63, 7, 32'h5555_0005, 32'h7777_0007, 32'h7777_0007); // Unassigned opcode
	endtask

	// Starts and ends 1 ns after a rising edge
	task automatic apply_row(input int i);
		while (!instr_ready) begin
			@(posedge clk);
			#1;
		end
		instr_valid = 1'b1;
		instr       = rows[i].ins;
		pc          = rows[i].pcv;
		wb_en       = rows[i].pre_en;
		wb_reg      = rows[i].pre_reg;
		wb_data     = rows[i].pre_data;
		pop_en      = rows[i].pop;
		pop_data    = rows[i].pop_val;
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
		wb_en       = 1'b0;
		pop_en      = 1'b0;
		while (!ex_valid) begin
			@(posedge clk);
			#1;
		end
		check_val(ex_opcode, rows[i].e_op, $sformatf("row %0d opcode", i));
		check_val(ex_dest, rows[i].e_dest, $sformatf("row %0d dest", i));
		check_val(ex_alu_a, rows[i].e_a, $sformatf("row %0d alu_a", i));
		check_val(ex_alu_b, rows[i].e_b, $sformatf("row %0d alu_b", i));
		check_val(ex_mem_data, rows[i].e_md, $sformatf("row %0d mem_data", i));
		check_val(ex_jump_target, rows[i].ins[25:0], $sformatf("row %0d jump_target", i));
		check_val(ex_pc, rows[i].pcv, $sformatf("row %0d pc", i));
		ex_credit = 1'b1; // Hand the slot back
		@(posedge clk);
		#1;
		ex_credit = 1'b0;
	endtask

	// One cycle against a reference credit count
	task automatic credit_cycle(input logic valid, input logic credit, input logic hazard);
		logic exp_ready;
		logic acc;
		instr_valid = valid;
		ex_credit   = credit;
		data_hazard = hazard;
		exp_ready   = (model_credits != 0) && !hazard;
		acc         = valid && exp_ready;
		#1;
		check_val(instr_ready, exp_ready, "instr_ready");
		@(posedge clk);
		#1;
		check_val(ex_valid, acc, "ex_valid one cycle after accept");
		model_credits = model_credits + int'(credit) - int'(acc);
		if (ex_valid)
			issued++;
		if (credit)
			returned++;
		check_val(issued <= returned + CREDITS, 1, "issues within returned credits");
	endtask

	task automatic run_credit_phase();
		int start;
		logic v, h, c;
		issued        = 0;
		returned      = 0;
		model_credits = CREDITS; // All slots back after the table
		instr         = enc_r(OPC_XOR, 2, 9, 7, 0);
		repeat (3) credit_cycle(1, 0, 1); // Hazard blocks issue
		start = issued;
		repeat (CREDITS + 3) credit_cycle(1, 0, 0); // No returns
		check_val(issued - start, CREDITS, "issues without returns");
		check_val(instr_ready, 0, "instr_ready with no credits");
		for (int n = 0; n < RAND_CYCLES; n++) begin
			v = ($urandom % 4) != 0;
			h = ($urandom % 6) == 0;
			c = (issued > returned) && (($urandom % 3) == 0);
			credit_cycle(v, c, h);
		end
		while (issued > returned)
			credit_cycle(0, 1, 0); // Drain
		credit_cycle(0, 0, 0);
		check_val(instr_ready, 1, "instr_ready after drain");
	endtask

	initial begin
		void'($urandom(32'h90af_5135));
		clk         = 1'b0;
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		pc          = '0;
		data_hazard = 1'b0;
		wb_en       = 1'b0;
		wb_reg      = '0;
		wb_data     = '0;
		pop_en      = 1'b0;
		pop_data    = '0;
		ex_credit   = 1'b0;
		build_table();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		check_val(ex_valid, 0, "ex_valid after reset");
		check_val(instr_ready, 1, "instr_ready after reset");
		for (int i = 0; i < N_ROWS; i++)
			apply_row(i);
		run_credit_phase();
		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/regfile_if.sv
hdl/decode_control.sv
hdl/reg_file.sv
hdl/id_unit.sv
hdl/issue_credit.sv
hdl/decode_stage.sv
testbench/tb_decode_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_decode_stage
LOG=sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module "$TOP" -o "sim_$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./obj_dir/sim_$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
